/* sim/pulse_stim.txt */
# kind payload ctrl checksum expected, all hex, one frame per line
# kind 0 echo, 1 random payload, 2 first width, 3 gap, 4 last width, 5 period, 6 count, 7 tail, 8 no wait
5 12345678 ff 14 0400
2 00000000 ee 00 0006
3 a5000000 ee a5 0014
4 0000005a 77 5a 0006
6 00000000 fe 00 0002
7 00000000 fd 00 000a
1 00000000 c3 00 0000
1 00000000 c3 00 0000
1 00000000 c3 00 0000
3 00000030 00 30 0030
2 00000009 02 09 0009
4 0000000c 03 0c 000c
5 00000002 01 02 0200
6 00000004 05 04 0005
3 00000030 ee 30 0030
6 00000a02 04 0c 0004
7 00002003 04 23 0020
7 00002001 04 21 0000
8 11223344 c0 aa 0000
8 01020304 c1 0a 0000
8 ffffffff c2 fc 0000
0 80808080 c3 00 0000

/* files.f */
hdl/pulse_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/pulse_control.sv
hdl/pulse_sequencer.sv
hdl/pulse_programmer_top.sv
sim/pulse_programmer_asserts.sv
sim/tb_pulse_programmer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pulse programmer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_pulse_programmer -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0

/* sim/tb_pulse_programmer.sv */
module tb_pulse_programmer;
	import pulse_pkg::*;

	logic        clk;
	logic        rst;
	logic        rx;
	logic        tx;
	logic        cmd_done;
	logic        sync;
	logic        pulse;
	logic        blank;
	integer      seed;
	integer      errors;
	integer      tests;
	integer      fd;
	integer      timed_out;
	logic [7:0]  rx_q[$]; // bytes seen on tx
	logic [7:0]  exp_q[$]; // echoes still owed
	logic [7:0]  done_cnt;
	logic [7:0]  frames;
	logic [15:0] w_first, w_last, gap_min, gap_max, per_len, tail;
	logic [7:0]  npulse;

	pulse_programmer_top u_pulse_programmer_top (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.tx       (tx),
		.cmd_done (cmd_done),
		.sync     (sync),
		.pulse    (pulse),
		.blank    (blank)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst)
			done_cnt <= '0;
		else if (cmd_done)
			done_cnt <= done_cnt + 8'd1; // one per applied frame
	end

	// rebuild echo bytes, sampled mid bit
	initial begin : echo_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (!rst && tx === 1'b0) begin
				repeat (clks_per_bit / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (clks_per_bit) @(negedge clk);
					b[i] = tx;
				end
				repeat (clks_per_bit) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("echo byte on tx has a bad stop bit at %0t", $time);
					errors++;
				end
				rx_q.push_back(b);
			end
		end
	end

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] f;
		f = {1'b1, b, 1'b0}; // stop, data, start
		for (int i = 0; i < 10; i++) begin
			rx = f[i];
			repeat (clks_per_bit) @(negedge clk);
		end
	endtask

	task automatic send_frame(input logic [31:0] p, input logic [7:0] c);
		for (int i = 0; i < 4; i++)
			send_byte(p[8 * i +: 8]); // lsb first
		send_byte(c);
		frames = frames + 8'd1;
	endtask

	// sum of the four payload bytes mod 256
	function automatic logic [7:0] payload_sum(input cmd_payload_u pl);
		logic [7:0] s;
		s = '0;
		for (int i = 0; i < 4; i++)
			s = s + pl.raw[8 * i +: 8];
		return s;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_width(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_echo;
		integer n;
		n = 0;
		while (rx_q.size() < exp_q.size() && n < 4000) begin
			@(negedge clk);
			n++;
		end
		if (rx_q.size() < exp_q.size()) begin
			$display("timed out waiting for an echo byte on tx");
			errors++;
			timed_out = 1;
		end else begin
			while (exp_q.size() > 0)
				check_byte("echo", rx_q.pop_front(), exp_q.pop_front()); // in order
			if (rx_q.size() != 0) begin
				$display("more echo bytes came back than frames were sent");
				errors++;
			end
			check_count("cmd_done pulses", done_cnt, frames);
		end
	endtask

	task automatic wait_sync;
		integer n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (sync !== 1'b1 && n < 70000);
		if (sync !== 1'b1) begin
			$display("timed out waiting for sync");
			errors++;
			timed_out = 1;
		end
	endtask

	// one full period, starting from the sync after the next one
	task automatic measure_period;
		logic [15:0] run;
		logic [15:0] low_run;
		logic        prev;
		wait_sync;
		if (timed_out == 0)
			wait_sync;
		per_len = '0;
		run = '0;
		low_run = '0;
		prev = 1'b0;
		npulse = '0;
		gap_min = '1;
		gap_max = '0;
		w_first = '0;
		w_last = '0;
		tail = '0;
		if (timed_out == 0) begin
			do begin
				@(negedge clk);
				per_len++;
				if (pulse && !prev) begin
					if (npulse != 8'd0) begin
						if (low_run < gap_min) gap_min = low_run;
						if (low_run > gap_max) gap_max = low_run;
					end
					npulse++;
					run = '0;
				end
				if (pulse) begin
					run++;
				end else begin
					if (prev) begin // falling edge
						if (npulse == 8'd1) w_first = run;
						w_last = run;
						low_run = '0;
						tail = '0;
					end
					low_run++;
					if (blank && npulse != 8'd0) tail++; // blank after last pulse
				end
				prev = pulse;
			end while (sync !== 1'b1 && per_len < 16'hffff);
			if (sync !== 1'b1) begin
				$display("timed out waiting for the end of a period");
				errors++;
				timed_out = 1;
			end
		end
	endtask

	initial begin : main
		string        line;
		integer       kind;
		integer       n;
		integer       err0;
		logic [31:0]  payload;
		logic [7:0]   ctrl, sum, rsum;
		logic [15:0]  expv;
		cmd_payload_u pl;
		seed = 32'hea7a_60b4;
		errors = 0;
		tests = 0;
		timed_out = 0;
		frames = '0;
		rst = 1'b1;
		rx = 1'b1; // idle line
		repeat (3) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("sim/pulse_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd) && timed_out == 0) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != 8'h23 &&
					$sscanf(line, "%h %h %h %h %h", kind, payload, ctrl, sum, expv) == 5) begin
					tests++;
					err0 = errors;
					if (kind == 1)
						payload = $random(seed); // checksum only
					pl.raw = payload;
					rsum = payload_sum(pl);
					if (kind != 1)
						check_byte("stim checksum column", sum, rsum);
					exp_q.push_back((kind == 1) ? rsum : sum);
					send_frame(payload, ctrl);
					if (kind != 8)
						wait_echo; // kind 8 goes back to back
					if (kind >= 2 && kind <= 7 && timed_out == 0) begin
						measure_period;
						case (kind)
							2: check_width("first pulse width", w_first, expv);
							3: begin
								check_width("shortest gap", gap_min, expv);
								check_width("longest gap", gap_max, expv);
							end
							4: check_width("last pulse width", w_last, expv);
							5: check_width("period", per_len, expv);
							6: check_count("pulse count", npulse, expv[7:0]);
							default: check_width("blank tail", tail, expv);
						endcase
					end
					$display("test %0d kind %0d: %s", tests, kind,
						(errors == err0) ? "passed" : "failed");
				end
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin : watchdog
		repeat (600000) @(posedge clk);
		$display("simulation ran too long and was stopped");
		$display("** FAIL **");
		$finish;
	end

endmodule

/* sim/pulse_programmer_asserts.sv */
module pulse_programmer_asserts (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic pulse,
	input logic blank,
	input logic blk_en, // blanking with a tail, latched at sync
	input logic tx_start,
	input logic tx_busy
);

	sync_one_cycle: assert property (@(posedge clk) disable iff (rst)
		sync |=> !sync)
		else $error("sync held longer than one cycle");

	// blank holds through the gap or tail after each pulse
	blank_after_pulse: assert property (@(posedge clk) disable iff (rst)
		(blk_en && !sync && $fell(pulse)) |-> blank)
		else $error("blank dropped as a pulse fell");

	start_when_idle: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

bind pulse_sequencer pulse_programmer_asserts u_seq_asserts (
	.clk      (clk),
	.rst      (rst),
	.sync     (sync),
	.pulse    (pulse),
	.blank    (blank),
	.blk_en   (blk_en_q && (blk_len_q != 8'd0)),
	.tx_start (1'b0),
	.tx_busy  (1'b0)
);

bind pulse_control pulse_programmer_asserts u_ctrl_asserts (
	.clk      (clk),
	.rst      (rst),
	.sync     (1'b0),
	.pulse    (1'b0),
	.blank    (1'b0),
	.blk_en   (1'b0),
	.tx_start (tx_start),
	.tx_busy  (tx_busy)
);

/* hdl/pulse_programmer_top.sv */
module pulse_programmer_top (
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx,
	output logic cmd_done,
	output logic sync,
	output logic pulse,
	output logic blank
);
	logic        rx_valid;
	logic [7:0]  rx_data;
	logic        tx_start;
	logic [7:0]  tx_data; // checksum echo
	logic        tx_busy;
	logic [7:0]  period;
	logic [15:0] p1width;
	logic [15:0] delay;
	logic [15:0] p2width;
	logic [7:0]  cpmg;
	logic [7:0]  block_len;
	logic        pump;
	logic        block_en;

	uart_rx u_rx (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	uart_tx u_tx (
		.clk      (clk),
		.rst      (rst),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

	// frame decode and timing registers
	pulse_control u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.tx_busy   (tx_busy),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.cmd_done  (cmd_done),
		.period    (period),
		.p1width   (p1width),
		.delay     (delay),
		.p2width   (p2width),
		.cpmg      (cpmg),
		.block_len (block_len),
		.pump      (pump),
		.block_en  (block_en)
	);

	pulse_sequencer u_seq (
		.clk       (clk),
		.rst       (rst),
		.period    (period),
		.p1width   (p1width),
		.delay     (delay),
		.p2width   (p2width),
		.cpmg      (cpmg),
		.block_len (block_len),
		.pump      (pump),
		.block_en  (block_en),
		.sync      (sync),
		.pulse     (pulse),
		.blank     (blank)
	);

endmodule

/* hdl/pulse_sequencer.sv */
module pulse_sequencer (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  period,
	input  logic [15:0] p1width,
	input  logic [15:0] delay,
	input  logic [15:0] p2width,
	input  logic [7:0]  cpmg,
	input  logic [7:0]  block_len,
	input  logic        pump,
	input  logic        block_en,
	output logic        sync,
	output logic        pulse,
	output logic        blank
);
	import pulse_pkg::*;

	logic [15:0] pcnt; // cycles left in period
	logic [15:0] cnt; // cycles left in phase
	logic [2:0]  phase;
	logic [2:0]  tail_next;
	logic [7:0]  rcnt; // refocus pulses done
	logic        seen; // first pulse edge passed
	logic [15:0] p1_q, dly_q, p2_q; // copies taken at sync
	logic [7:0]  cpmg_q, blk_len_q;
	logic        pump_q, blk_en_q;

	always_ff @(posedge clk) begin
		if (pcnt == 16'd0) begin
			p1_q <= p1width;
			dly_q <= delay;
			p2_q <= p2width;
			cpmg_q <= cpmg;
			blk_len_q <= block_len;
			pump_q <= pump;
			blk_en_q <= block_en;
		end
	end

	assign tail_next = (blk_len_q == 8'd0) ? ph_idle : ph_tail; // no tail when length 0

	always_ff @(posedge clk) begin
		if (rst) begin
			sync <= 1'b0;
			pcnt <= '0; // first sync right after reset
			cnt <= '0;
			phase <= ph_idle;
			rcnt <= '0;
			seen <= 1'b0;
		end else if (pcnt == 16'd0) begin
			sync <= 1'b1;
			pcnt <= 16'(period * period_unit - 1);
			phase <= ph_idle; // truncate overrun
			rcnt <= '0;
			seen <= 1'b0;
		end else begin
			sync <= 1'b0;
			pcnt <= pcnt - 16'd1;
			if (sync) begin
				seen <= pump_q;
				phase <= pump_q ? ph_pump : ph_gap;
				cnt <= (pump_q ? p1_q : dly_q) - 16'd1;
			end else if (phase != ph_idle && cnt != 16'd0) begin
				cnt <= cnt - 16'd1;
			end else begin
				case (phase)
					ph_pump: begin
						phase <= ph_gap;
						cnt <= dly_q - 16'd1;
					end
					ph_gap: begin
						if (rcnt < cpmg_q) begin
							phase <= ph_refocus;
							cnt <= p2_q - 16'd1;
							seen <= 1'b1;
						end else begin
							phase <= tail_next; // cpmg of 0
							cnt <= {8'd0, blk_len_q} - 16'd1;
						end
					end
					ph_refocus: begin
						rcnt <= rcnt + 8'd1;
						phase <= (rcnt + 8'd1 < cpmg_q) ? ph_gap : tail_next;
						cnt <= ((rcnt + 8'd1 < cpmg_q) ? dly_q : {8'd0, blk_len_q}) - 16'd1;
					end
					ph_tail: phase <= ph_idle;
					default: ;
				endcase
			end
		end
	end

	assign pulse = (phase == ph_pump) || (phase == ph_refocus);
	// blank spans first pulse through tail
	assign blank = blk_en_q && (pulse || (seen && (phase == ph_gap || phase == ph_tail)));

endmodule

/* hdl/pulse_control.sv */
module pulse_control (
	input  logic        clk,
	input  logic        rst,
	input  logic        rx_valid,
	input  logic [7:0]  rx_data,
	input  logic        tx_busy,
	output logic        tx_start,
	output logic [7:0]  tx_data,
	output logic        cmd_done,
	output logic [7:0]  period,
	output logic [15:0] p1width,
	output logic [15:0] delay,
	output logic [15:0] p2width,
	output logic [7:0]  cpmg,
	output logic [7:0]  block_len,
	output logic        pump,
	output logic        block_en
);
	import pulse_pkg::*;

	cmd_payload_u payload; // four bytes, lsb first
	logic [7:0]   ctrl_code;
	logic [2:0]   byte_cnt;
	logic [1:0]   state;

	// payload and control byte capture
	always_ff @(posedge clk) begin
		if (state == ctl_recv && rx_valid) begin
			if (byte_cnt == 3'd4)
				ctrl_code <= rx_data;
			else
				payload.raw[8 * byte_cnt +: 8] <= rx_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ctl_recv;
			byte_cnt <= '0;
			tx_start <= 1'b0;
			cmd_done <= 1'b0;
			period <= rst_period;
			p1width <= rst_p1width;
			p2width <= rst_p2width;
			delay <= rst_delay;
			cpmg <= rst_cpmg;
			pump <= rst_pump;
			block_en <= rst_block_en;
			block_len <= rst_block_len;
		end else begin
			tx_start <= 1'b0; // strobes
			cmd_done <= 1'b0;
			case (state)
				ctl_recv: begin
					if (rx_valid) begin
						if (byte_cnt == 3'd4) begin
							byte_cnt <= '0;
							state <= ctl_apply;
						end else
							byte_cnt <= byte_cnt + 3'd1;
					end
				end
				ctl_apply: begin
					case (ctrl_code)
						cmd_set_delay:  delay <= payload.raw[15:0];
						cmd_set_period: period <= payload.raw[7:0];
						cmd_set_pulse1: p1width <= payload.raw[15:0];
						cmd_set_pulse2: p2width <= payload.raw[15:0];
						cmd_toggle: begin
							pump <= payload.toggle.pump;
							block_en <= payload.toggle.block_en;
							block_len <= payload.toggle.block_len;
						end
						cmd_set_cpmg:   cpmg <= payload.raw[7:0];
						default: ; // unknown code, echo only
					endcase
					cmd_done <= 1'b1;
					if (!tx_busy) begin
						tx_start <= 1'b1; // goes out with cmd_done
						state <= ctl_recv;
					end else
						state <= ctl_send;
				end
				default: begin
					// previous echo still on the line
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state <= ctl_recv;
					end
				end
			endcase
		end
	end

	// checksum, sum of payload bytes mod 256
	always_ff @(posedge clk) begin
		if (state == ctl_apply)
			tx_data <= payload.raw[7:0] + payload.raw[15:8] + payload.raw[23:16]
				+ payload.raw[31:24];
	end

endmodule

/* hdl/uart_tx.sv */
module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_busy
);
	import pulse_pkg::*;

	logic [9:0]           shift; // stop, data, start with start in bit 0
	logic [bit_cnt_w-1:0] cnt;
	logic [3:0]           bit_idx; // bits sent so far

	assign tx = shift[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			shift <= '1; // idle high
			tx_busy <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			cnt <= '0;
			bit_idx <= '0;
			if (tx_start) begin
				shift <= {1'b1, tx_data, 1'b0};
				tx_busy <= 1'b1;
			end
		end else if (cnt == bit_cnt_w'(clks_per_bit - 1)) begin
			cnt <= '0;
			shift <= {1'b1, shift[9:1]}; // refill with idle level
			if (bit_idx == 4'd9)
				tx_busy <= 1'b0; // stop bit done
			else
				bit_idx <= bit_idx + 4'd1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* hdl/uart_rx.sv */
module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic       rx_valid,
	output logic [7:0] rx_data
);
	import pulse_pkg::*;

	logic                 rx_meta; // first sync stage
	logic                 rx_sync;
	logic [1:0]           state;
	logic [bit_cnt_w-1:0] cnt; // clocks within current bit
	logic [2:0]           bit_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1; // line idles high
			rx_sync <= 1'b1;
			state <= rxs_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				rxs_idle: begin
					cnt <= '0;
					if (!rx_sync)
						state <= rxs_start; // falling edge, maybe a start bit
				end
				rxs_start: begin
					if (cnt == bit_cnt_w'(clks_per_bit / 2 - 1)) begin
						cnt <= '0;
						bit_idx <= '0;
						// still low at mid bit, otherwise a glitch
						state <= rx_sync ? rxs_idle : rxs_bits;
					end else
						cnt <= cnt + 1'b1;
				end
				rxs_bits: begin
					if (cnt == bit_cnt_w'(clks_per_bit - 1)) begin
						cnt <= '0;
						rx_data <= {rx_sync, rx_data[7:1]}; // lsb first
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= rxs_stop;
					end else
						cnt <= cnt + 1'b1;
				end
				default: begin // stop bit
					if (cnt == bit_cnt_w'(clks_per_bit - 1)) begin
						rx_valid <= rx_sync; // bad stop bit drops the byte
						state <= rxs_idle;
					end else
						cnt <= cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

/* hdl/pulse_pkg.sv */
package pulse_pkg;

	// uart bit timing
	localparam int clks_per_bit = 16; // clk cycles per serial bit
	localparam int bit_cnt_w = $clog2(clks_per_bit);

	localparam int period_unit = 256; // clk cycles per count of the period register

	// control byte codes
	localparam logic [7:0] cmd_set_delay = 8'd0;
	localparam logic [7:0] cmd_set_period = 8'd1;
	localparam logic [7:0] cmd_set_pulse1 = 8'd2;
	localparam logic [7:0] cmd_set_pulse2 = 8'd3;
	localparam logic [7:0] cmd_toggle = 8'd4;
	localparam logic [7:0] cmd_set_cpmg = 8'd5;

	// power-up timing
	localparam logic [7:0] rst_period = 8'd4; // 4 x 256 cycles
	localparam logic [15:0] rst_p1width = 16'd6;
	localparam logic [15:0] rst_p2width = 16'd6;
	localparam logic [15:0] rst_delay = 16'd20;
	localparam logic [7:0] rst_cpmg = 8'd1; // hahn echo
	localparam logic rst_pump = 1'b1;
	localparam logic rst_block_en = 1'b1;
	localparam logic [7:0] rst_block_len = 8'd10;

	// fsm encodings
	localparam logic [1:0] rxs_idle = 2'd0;
	localparam logic [1:0] rxs_start = 2'd1;
	localparam logic [1:0] rxs_bits = 2'd2;
	localparam logic [1:0] rxs_stop = 2'd3;

	localparam logic [1:0] ctl_recv = 2'd0;
	localparam logic [1:0] ctl_apply = 2'd1;
	localparam logic [1:0] ctl_send = 2'd2;

	localparam logic [2:0] ph_idle = 3'd0;
	localparam logic [2:0] ph_pump = 3'd1;
	localparam logic [2:0] ph_gap = 3'd2;
	localparam logic [2:0] ph_refocus = 3'd3;
	localparam logic [2:0] ph_tail = 3'd4;

	// frame payload, plain word or toggle fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] unused_hi;
			logic [7:0]  block_len; // blank tail after last pulse
			logic [5:0]  unused_lo;
			logic        block_en;
			logic        pump;
		} toggle;
	} cmd_payload_u;

endpackage
